// File: design/axis_mon_pkg.sv
package axis_mon_pkg;

    // Stream field widths
    localparam int DATA_W     = 32;
    localparam int STRB_W     = DATA_W / 8;
    localparam int ID_W       = 8;
    localparam int DEST_W     = 2;
    localparam int USER_W     = 1;
    localparam int NBYTES_W   = $clog2(STRB_W + 1);

    // Statistics and register side
    localparam int NUM_DEST   = 1 << DEST_W;
    localparam int PKT_CNT_W  = 16;
    localparam int BYTE_CNT_W = 32;
    localparam int WB_ADR_W   = 4;
    localparam int WB_DAT_W   = 32;

    // Skid buffer sizing
    localparam int SKID_DEPTH = 4;
    localparam int SKID_CNT_W = $clog2(SKID_DEPTH + 1);

    typedef logic [DATA_W-1:0]     data_t;
    typedef logic [STRB_W-1:0]     strb_t;
    typedef logic [ID_W-1:0]       id_t;
    typedef logic [DEST_W-1:0]     dest_t;
    typedef logic [USER_W-1:0]     user_t;
    typedef logic [NBYTES_W-1:0]   nbytes_t;
    typedef logic [BYTE_CNT_W-1:0] byte_cnt_t;
    typedef logic [PKT_CNT_W-1:0]  pkt_cnt_t;
    typedef logic [WB_ADR_W-1:0]   wb_adr_t;
    typedef logic [WB_DAT_W-1:0]   wb_dat_t;

    // One stream beat, data in the top bits
    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
        id_t   id;
        dest_t dest;
        user_t user;
    } axis_beat_t;

    localparam int BEAT_W = $bits(axis_beat_t);

    // Decoded view of one transferred beat
    typedef struct packed {
        logic    valid;
        dest_t   dest;
        nbytes_t nbytes;
        logic    last;
    } beat_info_t;

    // Low word address bit selects the counter kind
    localparam logic REG_PKT   = 1'b0;
    localparam logic REG_BYTES = 1'b1;

endpackage : axis_mon_pkg

// File: design/gaxi_skid_buffer.sv
`timescale 1ns/1ps

module gaxi_skid_buffer #(
    parameter int DEPTH      = 4,
    parameter int DATA_WIDTH = 32
) (
    input  logic                         aclk,
    input  logic                         arst_n,
    input  logic                         wr_valid,
    output logic                         wr_ready,
    input  logic [DATA_WIDTH-1:0]        wr_data,
    output logic                         rd_valid,
    input  logic                         rd_ready,
    output logic [DATA_WIDTH-1:0]        rd_data,
    output logic [$clog2(DEPTH+1)-1:0]   rd_count
);

    localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    logic [DATA_WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]         wr_ptr;
    logic [AW-1:0]         rd_ptr;
    logic [CW-1:0]         count;
    logic                  full;
    logic                  wr_fire;
    logic                  rd_fire;

    // Pointer step that also handles non power of two depths
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        if (p == AW'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign wr_ready = !full;
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];
    assign rd_count = count;
    assign wr_fire  = wr_valid && wr_ready;
    assign rd_fire  = rd_valid && rd_ready;

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (rd_fire) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            // Simultaneous push and pop leaves the level unchanged
            case ({wr_fire, rd_fire})
                2'b10: begin
                    count <= count + 1'b1;
                    full  <= (count == CW'(DEPTH - 1));
                end
                2'b01: begin
                    count <= count - 1'b1;
                    full  <= 1'b0;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Registered full flag must track the level
    a_no_write_when_full: assert property (@(posedge aclk) disable iff (!arst_n)
        wr_fire |-> (count != CW'(DEPTH)));

    // Output beat held until taken
    a_rd_stable: assert property (@(posedge aclk) disable iff (!arst_n)
        rd_valid && !rd_ready |=> rd_valid && $stable(rd_data));

endmodule : gaxi_skid_buffer

// File: design/axis_slave.sv
`timescale 1ns/1ps

module axis_slave
    import axis_mon_pkg::*;
(
    input  logic       aclk,
    input  logic       arst_n,

    // Input stream
    input  axis_beat_t s_axis_beat,
    input  logic       s_axis_tvalid,
    output logic       s_axis_tready,

    // Backend stream
    output axis_beat_t m_axis_beat,
    output logic       m_axis_tvalid,
    input  logic       m_axis_tready,

    // Activity flag for clock gating
    output logic       busy
);

    logic [SKID_CNT_W-1:0] skid_count;
    logic [BEAT_W-1:0]     skid_rd_data;

    // Anything stored or anything arriving keeps the block awake
    assign busy = (skid_count != '0) || s_axis_tvalid;

    gaxi_skid_buffer #(
        .DEPTH      (SKID_DEPTH),
        .DATA_WIDTH (BEAT_W)
    ) t_skid_inst (
        .aclk     (aclk),
        .arst_n   (arst_n),
        .wr_valid (s_axis_tvalid),
        .wr_ready (s_axis_tready),
        .wr_data  (s_axis_beat),
        .rd_valid (m_axis_tvalid),
        .rd_ready (m_axis_tready),
        .rd_data  (skid_rd_data),
        .rd_count (skid_count)
    );

    // Whole beat comes back out as the struct
    assign m_axis_beat = axis_beat_t'(skid_rd_data);

endmodule : axis_slave

// File: design/axis_beat_decode.sv
`timescale 1ns/1ps

module axis_beat_decode
    import axis_mon_pkg::*;
(
    input  logic       aclk,
    input  logic       arst_n,
    input  axis_beat_t beat,
    input  logic       fire,
    output beat_info_t info
);

    nbytes_t nbytes_c;
    logic    valid_q;
    dest_t   dest_q;
    nbytes_t nbytes_q;
    logic    last_q;

    // Byte count is the number of set strobe bits
    always_comb begin
        nbytes_c = '0;
        for (int i = 0; i < STRB_W; i++) begin
            nbytes_c = nbytes_c + nbytes_t'(beat.strb[i]);
        end
    end

    // One valid pulse per backend handshake
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= fire;
        end
    end

    always_ff @(posedge aclk) begin
        if (fire) begin
            dest_q   <= beat.dest;
            nbytes_q <= nbytes_c;
            last_q   <= beat.last;
        end
    end

    assign info = '{
        valid:  valid_q,
        dest:   dest_q,
        nbytes: nbytes_q,
        last:   last_q
    };

endmodule : axis_beat_decode

// File: design/axis_stat_accum.sv
`timescale 1ns/1ps

module axis_stat_accum
    import axis_mon_pkg::*;
(
    input  logic                         aclk,
    input  logic                         arst_n,
    input  beat_info_t                   info,
    input  logic      [NUM_DEST-1:0]     clr_pkt,
    input  logic      [NUM_DEST-1:0]     clr_bytes,
    output pkt_cnt_t  [NUM_DEST-1:0]     pkt_cnt,
    output byte_cnt_t [NUM_DEST-1:0]     byte_cnt
);

    pkt_cnt_t  [NUM_DEST-1:0] pkt_q;
    pkt_cnt_t  [NUM_DEST-1:0] pkt_nxt;
    byte_cnt_t [NUM_DEST-1:0] byte_q;
    byte_cnt_t [NUM_DEST-1:0] byte_nxt;

    // Next value per destination
    // a clear drops the old total but keeps this cycle's increment
    always_comb begin
        logic     hit;
        pkt_cnt_t pkt_inc;
        byte_cnt_t byte_inc;

        for (int d = 0; d < NUM_DEST; d++) begin
            hit      = info.valid && (info.dest == dest_t'(d));
            pkt_inc  = pkt_cnt_t'(hit && info.last);
            byte_inc = hit ? byte_cnt_t'(info.nbytes) : '0;

            if (clr_pkt[d]) begin
                pkt_nxt[d] = pkt_inc;
            end else begin
                pkt_nxt[d] = pkt_q[d] + pkt_inc;
            end

            if (clr_bytes[d]) begin
                byte_nxt[d] = byte_inc;
            end else begin
                byte_nxt[d] = byte_q[d] + byte_inc;
            end
        end
    end

    // Counters wrap naturally at their width
    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            pkt_q  <= '0;
            byte_q <= '0;
        end else begin
            pkt_q  <= pkt_nxt;
            byte_q <= byte_nxt;
        end
    end

    assign pkt_cnt  = pkt_q;
    assign byte_cnt = byte_q;

endmodule : axis_stat_accum

// File: design/axis_stat_wb.sv
`timescale 1ns/1ps

module axis_stat_wb
    import axis_mon_pkg::*;
(
    input  logic                         aclk,
    input  logic                         arst_n,

    // Wishbone classic slave
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  wb_adr_t                      wb_adr,
    input  wb_dat_t                      wb_dat_w,
    output wb_dat_t                      wb_dat_r,
    output logic                         wb_ack,

    // Counter access
    input  pkt_cnt_t  [NUM_DEST-1:0]     pkt_cnt,
    input  byte_cnt_t [NUM_DEST-1:0]     byte_cnt,
    output logic      [NUM_DEST-1:0]     clr_pkt,
    output logic      [NUM_DEST-1:0]     clr_bytes
);

    logic    req;
    logic    in_map;
    dest_t   sel;
    wb_dat_t rd_val;
    logic    ack_q;
    wb_dat_t dat_q;

    // New access, not the cycle already being acked
    assign req    = wb_cyc && wb_stb && !ack_q;
    assign in_map = (wb_adr[WB_ADR_W-1:DEST_W+1] == '0);
    assign sel    = dest_t'(wb_adr[DEST_W:1]);

    always_comb begin
        rd_val = '0;
        if (in_map) begin
            if (wb_adr[0] == REG_BYTES) begin
                rd_val = wb_dat_t'(byte_cnt[sel]);
            end else begin
                rd_val = wb_dat_t'(pkt_cnt[sel]);
            end
        end
    end

    // Clear lands on the same edge that raises ack, write data ignored
    always_comb begin
        for (int d = 0; d < NUM_DEST; d++) begin
            clr_pkt[d]   = req && wb_we && in_map && (sel == dest_t'(d))
                           && (wb_adr[0] == REG_PKT);
            clr_bytes[d] = req && wb_we && in_map && (sel == dest_t'(d))
                           && (wb_adr[0] == REG_BYTES);
        end
    end

    always_ff @(posedge aclk or negedge arst_n) begin
        if (!arst_n) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= req;
        end
    end

    always_ff @(posedge aclk) begin
        if (req) begin
            dat_q <= wb_we ? '0 : rd_val;
        end
    end

    assign wb_ack   = ack_q;
    assign wb_dat_r = dat_q;

    // Ack only ever answers a request from the previous cycle
    a_ack_after_req: assert property (@(posedge aclk) disable iff (!arst_n)
        wb_ack |-> $past(wb_cyc && wb_stb));

endmodule : axis_stat_wb

// File: design/axis_monitor_top.sv
`timescale 1ns/1ps

module axis_monitor_top
    import axis_mon_pkg::*;
(
    input  logic       aclk,
    input  logic       arst_n,

    // Input stream
    input  axis_beat_t s_axis_beat,
    input  logic       s_axis_tvalid,
    output logic       s_axis_tready,

    // Backend stream
    output axis_beat_t m_axis_beat,
    output logic       m_axis_tvalid,
    input  logic       m_axis_tready,
    output logic       busy,

    // Register port
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  wb_adr_t    wb_adr,
    input  wb_dat_t    wb_dat_w,
    output wb_dat_t    wb_dat_r,
    output logic       wb_ack
);

    beat_info_t                info;
    logic      [NUM_DEST-1:0]  clr_pkt;
    logic      [NUM_DEST-1:0]  clr_bytes;
    pkt_cnt_t  [NUM_DEST-1:0]  pkt_cnt;
    byte_cnt_t [NUM_DEST-1:0]  byte_cnt;

    axis_slave axis_slave_inst (
        .aclk          (aclk),
        .arst_n        (arst_n),
        .s_axis_beat   (s_axis_beat),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .m_axis_beat   (m_axis_beat),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .busy          (busy)
    );

    // Decoder watches the backend handshake
    axis_beat_decode axis_beat_decode_inst (
        .aclk   (aclk),
        .arst_n (arst_n),
        .beat   (m_axis_beat),
        .fire   (m_axis_tvalid && m_axis_tready),
        .info   (info)
    );

    axis_stat_accum axis_stat_accum_inst (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .info      (info),
        .clr_pkt   (clr_pkt),
        .clr_bytes (clr_bytes),
        .pkt_cnt   (pkt_cnt),
        .byte_cnt  (byte_cnt)
    );

    axis_stat_wb axis_stat_wb_inst (
        .aclk      (aclk),
        .arst_n    (arst_n),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .wb_dat_r  (wb_dat_r),
        .wb_ack    (wb_ack),
        .pkt_cnt   (pkt_cnt),
        .byte_cnt  (byte_cnt),
        .clr_pkt   (clr_pkt),
        .clr_bytes (clr_bytes)
    );

endmodule : axis_monitor_top

// File: tests/axis_monitor_tb.sv
`timescale 1ns/1ps

module axis_monitor_tb
    import axis_mon_pkg::*;
();

    localparam string CASE_FILE = "tests/axis_monitor_cases.txt";

    // One parsed line of the case file
    typedef struct packed {
        logic [7:0]  kind;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        logic [31:0] d;
    } case_op_t;

    logic       aclk;
    logic       arst_n;
    axis_beat_t s_axis_beat;
    logic       s_axis_tvalid;
    logic       s_axis_tready;
    axis_beat_t m_axis_beat;
    logic       m_axis_tvalid;
    logic       m_axis_tready;
    logic       busy;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    wb_adr_t    wb_adr;
    wb_dat_t    wb_dat_w;
    wb_dat_t    wb_dat_r;
    logic       wb_ack;

    case_op_t   ops[$];
    axis_beat_t drv_q[$];
    axis_beat_t exp_q[$];
    logic       stall;
    logic       accept_next;
    logic       take_next;
    logic [31:0] rng;
    int         level;
    int         n_beats;
    int         out_cnt;
    int         n_checks;
    int         n_mism;
    int         n_other;
    int         timeout_cycles;

    axis_monitor_top axis_monitor_top_inst (
        .aclk          (aclk),
        .arst_n        (arst_n),
        .s_axis_beat   (s_axis_beat),
        .s_axis_tvalid (s_axis_tvalid),
        .s_axis_tready (s_axis_tready),
        .m_axis_beat   (m_axis_beat),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .busy          (busy),
        .wb_cyc        (wb_cyc),
        .wb_stb        (wb_stb),
        .wb_we         (wb_we),
        .wb_adr        (wb_adr),
        .wb_dat_w      (wb_dat_w),
        .wb_dat_r      (wb_dat_r),
        .wb_ack        (wb_ack)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        n_checks++;
        if (got !== exp) begin
            n_mism++;
            $display("ERR %0t: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic push_beat(input case_op_t op);
        axis_beat_t b;
        b.data = data_t'(op.d);
        b.strb = strb_t'(op.b);
        b.last = op.c[0];
        b.id   = id_t'(n_beats);
        b.dest = dest_t'(op.a);
        b.user = user_t'(n_beats % 2);
        drv_q.push_back(b);
        exp_q.push_back(b);
        n_beats++;
    endtask

    // Stream drained, then two cycles for decode and accumulate
    task automatic wait_idle();
        @(negedge aclk);
        while (drv_q.size() != 0 || s_axis_tvalid || busy) begin
            @(negedge aclk);
        end
        repeat (2) @(negedge aclk);
    endtask

    // Starts on a falling edge, returns on a rising edge
    task automatic bus_access(input logic we, input wb_adr_t adr, output wb_dat_t data);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = we ? 32'hffff_ffff : 32'h0;
        @(negedge aclk);
        while (!wb_ack && waited < 8) begin
            @(negedge aclk);
            waited++;
        end
        data = wb_dat_r;
        if (!wb_ack) begin
            n_other++;
            $display("No Wishbone ack arrived for the access to address %0d", adr);
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge aclk);
        check(64'(wb_ack), 64'd0, "wb_ack low after access");
        @(posedge aclk);
    endtask

    // Back-pressure until the buffer fills, then release
    task automatic release_stall();
        @(negedge aclk);
        while (!(s_axis_tvalid && !s_axis_tready) && (drv_q.size() != 0 || s_axis_tvalid)) begin
            @(negedge aclk);
        end
        check(64'(s_axis_tready), 64'd0, "s_axis_tready with full buffer");
        @(posedge aclk);
        stall = 1'b0;
    endtask

    // Expected buffer level, moved by the handshakes set up on the falling edge
    always @(posedge aclk) begin
        level = level + int'(accept_next) - int'(take_next);
    end

    // Input stream driver
    initial begin
        forever begin
            @(negedge aclk);
            check(64'(busy), 64'((level != 0) || s_axis_tvalid), "busy");
            if (s_axis_tvalid && accept_next) begin
                s_axis_tvalid = 1'b0;
            end
            if (!s_axis_tvalid && drv_q.size() > 0) begin
                s_axis_beat   = drv_q.pop_front();
                s_axis_tvalid = 1'b1;
            end
            accept_next = s_axis_tvalid && s_axis_tready;
        end
    end

    // Random ready and output beat monitor
    initial begin
        axis_beat_t exp;
        forever begin
            @(negedge aclk);
            rng = next_random(rng);
            m_axis_tready = stall ? 1'b0 : (rng[1:0] != 2'b00);
            take_next = m_axis_tvalid && m_axis_tready;
            if (take_next) begin
                if (exp_q.size() == 0) begin
                    n_other++;
                    $display("Output beat %0d appeared with no input beat left", out_cnt);
                end else begin
                    exp = exp_q.pop_front();
                    check(64'(m_axis_beat), 64'(exp), $sformatf("output beat %0d", out_cnt));
                end
                out_cnt++;
            end
        end
    end

    initial begin
        wait (timeout_cycles != 0);
        repeat (timeout_cycles) @(posedge aclk);
        $display("Timeout after %0d cycles, stream or bus still pending", timeout_cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        int          fd;
        int          n;
        int          ch;
        logic [7:0]  kind;
        case_op_t    op;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [31:0] f_c;
        logic [31:0] f_d;
        wb_dat_t     rd;

        arst_n = 1'b0;
        s_axis_beat = '0;
        s_axis_tvalid = 1'b0;
        m_axis_tready = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        stall = 1'b0;
        accept_next = 1'b0;
        take_next = 1'b0;
        rng = 32'hba20d694;
        level = 0;
        n_beats = 0;
        out_cnt = 0;
        n_checks = 0;
        n_mism = 0;
        n_other = 0;
        timeout_cycles = 0;

        fd = $fopen(CASE_FILE, "r");
        if (fd == 0) begin
            n_other++;
            $display("Could not open the case file %s", CASE_FILE);
        end else begin
            while ($fscanf(fd, "%s", kind) == 1) begin
                f_a = '0;
                f_b = '0;
                f_c = '0;
                f_d = '0;
                n = 0;
                if (kind == "#") begin
                    ch = $fgetc(fd);
                    while (ch != "\n" && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else begin
                    if (kind == "B") begin
                        n = $fscanf(fd, "%h %h %h %h", f_a, f_b, f_c, f_d) - 4;
                    end else if (kind == "R") begin
                        n = $fscanf(fd, "%h %h", f_a, f_b) - 2;
                    end else if (kind == "W") begin
                        n = $fscanf(fd, "%h", f_a) - 1;
                    end else if (kind != "S" && kind != "G") begin
                        n = -1;
                    end
                    if (n != 0) begin
                        n_other++;
                        $display("Malformed case line of kind %c", kind);
                    end
                    ops.push_back('{kind: kind, a: f_a, b: f_b, c: f_c, d: f_d});
                end
            end
            $fclose(fd);
        end
        timeout_cycles = 200 * ops.size() + 100;

        repeat (4) @(posedge aclk);
        @(negedge aclk);
        arst_n = 1'b1;
        @(posedge aclk);

        foreach (ops[i]) begin
            op = ops[i];
            if (op.kind == "B") begin
                push_beat(op);
            end else if (op.kind == "R") begin
                wait_idle();
                bus_access(1'b0, wb_adr_t'(op.a), rd);
                check(64'(rd), 64'(op.b), $sformatf("read of address %0d", op.a));
            end else if (op.kind == "W") begin
                wait_idle();
                bus_access(1'b1, wb_adr_t'(op.a), rd);
            end else if (op.kind == "S") begin
                stall = 1'b1;
            end else if (op.kind == "G") begin
                release_stall();
            end
        end

        wait_idle();
        check(64'(out_cnt), 64'(n_beats), "number of output beats");
        $display("Checks %0d, value mismatches %0d, other failures %0d",
                 n_checks, n_mism, n_other);
        if (n_mism == 0 && n_other == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule : axis_monitor_tb

// File: tests/axis_monitor_cases.txt
# B dest strb last data | R word_addr expected | W word_addr (clear)
# S holds backend ready low, G waits for a full buffer and releases it
# Packet of mixed strobes to destination 1
B 1 f 0 a0000001
B 1 3 0 a0000002
B 1 8 1 a0000003
B 1 7 1 a0000004
R 2 2
R 3 a
# Interleaved traffic to all destinations
B 0 f 0 b0000000
B 2 c 1 b0000001
B 3 1 1 b0000002
B 0 5 1 b0000003
B 1 e 1 b0000004
R 1 6
R 4 1
R 5 2
R 7 1
R 3 d
# Clear the byte counter of destination 2
W 5
R 5 0
R 4 1
# Unmapped addresses
R 8 0
W 9
R f 0
# Back-pressure burst to destination 3
S
B 3 f 0 c0000000
B 3 f 0 c0000001
B 3 f 0 c0000002
B 3 f 0 c0000003
B 3 f 0 c0000004
B 3 f 1 c0000005
G
R 6 2
R 7 19
R 1 6

// File: sim.f
design/axis_mon_pkg.sv
design/gaxi_skid_buffer.sv
design/axis_slave.sv
design/axis_beat_decode.sv
design/axis_stat_accum.sv
design/axis_stat_wb.sv
design/axis_monitor_top.sv
tests/axis_monitor_tb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module axis_monitor_tb \
    -f sim.f -o axis_monitor_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/axis_monitor_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "RESULT: PASS"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
